// ==== arp/arp_cache.sv ====
// direct-mapped IP to MAC cache
// one write port from the decoder, one query port for the engine
`timescale 1ns/100ps
`include "arp_params.svh"

module arp_cache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear_cache,
    input  logic                  learn_valid,
    input  arp_pkg::cache_entry_t learn_entry,
    input  logic                  query_valid,
    input  arp_pkg::ip_t          query_ip,
    output logic                  query_hit,
    output arp_pkg::mac_t         query_mac
);

    localparam int ENTRIES = 2 ** `ARP_CACHE_ADDR_WIDTH;

    logic [ENTRIES-1:0]               valid_bits;
    arp_pkg::ip_t                     ip_mem  [ENTRIES];
    arp_pkg::mac_t                    mac_mem [ENTRIES];
    logic [`ARP_CACHE_ADDR_WIDTH-1:0] wr_idx;
    logic [`ARP_CACHE_ADDR_WIDTH-1:0] rd_idx;

    // index by the low IP bits
    assign wr_idx = learn_entry.ip[`ARP_CACHE_ADDR_WIDTH-1:0];
    assign rd_idx = query_ip[`ARP_CACHE_ADDR_WIDTH-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (clear_cache) begin
            valid_bits <= '0;
        end else if (learn_valid) begin
            valid_bits[wr_idx] <= 1'b1;
        end
    end

    // newer pair simply replaces whatever sat in the slot
    always_ff @(posedge clk) begin
        if (learn_valid) begin
            ip_mem[wr_idx]  <= learn_entry.ip;
            mac_mem[wr_idx] <= learn_entry.mac;
        end
    end

    // hit needs a valid slot and the full address to match
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            query_hit <= 1'b0;
        end else begin
            query_hit <= query_valid && valid_bits[rd_idx] && (ip_mem[rd_idx] == query_ip);
        end
    end

    always_ff @(posedge clk) begin
        query_mac <= mac_mem[rd_idx];
    end

endmodule

// ==== arp/arp_frame_decode.sv ====
// incoming ARP frame check and classification
// registers the learn pulse and the reply decision
`timescale 1ns/100ps
`include "arp_params.svh"

module arp_frame_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  arp_pkg::arp_frame_t   in_frame,
    input  logic                  in_frame_valid,
    input  logic                  rx_ready,
    input  arp_pkg::arp_cfg_t     cfg,
    output logic                  reply_valid,
    output logic [15:0]           reply_oper,
    output arp_pkg::mac_t         reply_dest_mac,
    output arp_pkg::cache_entry_t reply_target,
    output logic                  learn_valid,
    output arp_pkg::cache_entry_t learn_entry
);

    logic              accept;
    logic              frame_ok;
    logic              target_match;
    arp_pkg::arp_kind_e kind;

    assign accept = in_frame_valid & rx_ready;

    assign frame_ok = (in_frame.eth_type == `ARP_ETH_TYPE) &&
                      (in_frame.htype == `ARP_HTYPE_ETH) &&
                      (in_frame.ptype == `ARP_PTYPE_IPV4);

    always_comb begin
        if (in_frame.oper == `ARP_OPER_REQUEST) begin
            kind = arp_pkg::kind_request;
        end else if (in_frame.oper == `ARP_OPER_INARP_REQUEST) begin
            kind = arp_pkg::kind_inarp_request;
        end else begin
            kind = arp_pkg::kind_other;
        end
    end

    // ARP asks for our IP, InARP asks for our MAC
    assign target_match = (kind == arp_pkg::kind_request && in_frame.tpa == cfg.local_ip) ||
                          (kind == arp_pkg::kind_inarp_request &&
                           in_frame.tha == cfg.local_mac);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            learn_valid <= 1'b0;
            reply_valid <= 1'b0;
        end else begin
            learn_valid <= accept & frame_ok;
            reply_valid <= accept & frame_ok & target_match;
        end
    end

    // payload follows the frame, valid bits qualify it
    always_ff @(posedge clk) begin
        if (accept) begin
            learn_entry.ip  <= in_frame.spa;
            learn_entry.mac <= in_frame.sha;
            reply_target.ip  <= in_frame.spa;
            reply_target.mac <= in_frame.sha;
            reply_dest_mac   <= in_frame.eth_src_mac;
            reply_oper <= (kind == arp_pkg::kind_request) ? `ARP_OPER_REPLY
                                                          : `ARP_OPER_INARP_REPLY;
        end
    end

endmodule

// ==== arp/arp_frame_tx.sv ====
// outgoing frame slot
// merges replies from the decoder with request frames from the engine
// fills in local addresses and constant type fields
`timescale 1ns/100ps
`include "arp_params.svh"

module arp_frame_tx (
    input  logic                  clk,
    input  logic                  rst,
    input  arp_pkg::arp_cfg_t     cfg,
    input  logic                  reply_valid,
    input  logic [15:0]           reply_oper,
    input  arp_pkg::mac_t         reply_dest_mac,
    input  arp_pkg::cache_entry_t reply_target,
    input  logic                  send_request,
    input  arp_pkg::ip_t          request_ip,
    output logic                  rx_ready,
    output arp_pkg::arp_frame_t   out_frame,
    output logic                  out_frame_valid,
    input  logic                  out_frame_ready
);

    logic         req_pending;
    arp_pkg::ip_t req_ip;
    logic         slot_free;
    logic         load_req;

    function automatic arp_pkg::arp_frame_t build_frame(
        input arp_pkg::arp_cfg_t c,
        input arp_pkg::mac_t     dest,
        input logic [15:0]       oper,
        input arp_pkg::mac_t     tha,
        input arp_pkg::ip_t      tpa
    );
        arp_pkg::arp_frame_t f;
        f.eth_dest_mac = dest;
        f.eth_src_mac  = c.local_mac;
        f.eth_type     = `ARP_ETH_TYPE;
        f.htype        = `ARP_HTYPE_ETH;
        f.ptype        = `ARP_PTYPE_IPV4;
        f.oper         = oper;
        f.sha          = c.local_mac;
        f.spa          = c.local_ip;
        f.tha          = tha;
        f.tpa          = tpa;
        return f;
    endfunction

    assign slot_free = ~out_frame_valid | out_frame_ready;

    // a pending request loads as soon as the slot frees up
    assign load_req = req_pending & slot_free;

    // input frames wait until the slot is empty and no reply or request is on its way
    assign rx_ready = ~out_frame_valid & ~reply_valid & ~req_pending & ~send_request;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_frame_valid <= 1'b0;
            req_pending     <= 1'b0;
        end else begin
            if (reply_valid || load_req) begin
                out_frame_valid <= 1'b1;
            end else if (out_frame_ready) begin
                out_frame_valid <= 1'b0;
            end
            req_pending <= send_request | (req_pending & ~load_req);
        end
    end

    always_ff @(posedge clk) begin
        if (send_request) begin
            req_ip <= request_ip;
        end
        // request frames take priority over replies
        if (load_req) begin
            // broadcast request with unknown target MAC
            out_frame <= build_frame(cfg, 48'hffff_ffff_ffff, `ARP_OPER_REQUEST,
                                     48'h0, req_ip);
        end else if (reply_valid) begin
            out_frame <= build_frame(cfg, reply_dest_mac, reply_oper,
                                     reply_target.mac, reply_target.ip);
        end
    end

endmodule

// ==== arp/arp_lookup_engine.sv ====
// host lookup engine
// next hop selection, cache query, request retries and timeout
// states are idle, query and waiting
`timescale 1ns/100ps
`include "arp_params.svh"

module arp_lookup_engine (
    input  logic              clk,
    input  logic              rst,
    input  arp_pkg::arp_cfg_t cfg,
    input  logic              lookup_valid,
    input  arp_pkg::ip_t      lookup_ip,
    output logic              lookup_ready,
    output logic              query_valid,
    output arp_pkg::ip_t      query_ip,
    input  logic              query_hit,
    input  arp_pkg::mac_t     query_mac,
    output logic              send_request,
    output arp_pkg::ip_t      request_ip,
    output logic              response_valid,
    output logic              response_error,
    output arp_pkg::mac_t     response_mac
);

    localparam int RETRY_W = $clog2(`ARP_RETRY_COUNT + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_QUERY = 2'd1;
    localparam logic [1:0] ST_WAIT  = 2'd2;

    localparam logic [`ARP_TIMER_WIDTH-1:0] INTERVAL_LOAD =
        `ARP_TIMER_WIDTH'(`ARP_RETRY_INTERVAL - 1);
    localparam logic [`ARP_TIMER_WIDTH-1:0] TIMEOUT_LOAD =
        `ARP_TIMER_WIDTH'(`ARP_REQUEST_TIMEOUT - 1);

    logic [1:0]                 state;
    arp_pkg::ip_t               target_ip;
    logic                       bcast_resp;
    logic [RETRY_W-1:0]         retry_left;
    logic [`ARP_TIMER_WIDTH-1:0] timer;
    logic                       is_bcast;
    logic                       in_subnet;
    logic                       waiting;
    logic                       timer_done;
    logic                       give_up;

    // all host bits set
    assign is_bcast  = ((~(lookup_ip | cfg.subnet_mask)) == 32'd0);
    assign in_subnet = (((lookup_ip ^ cfg.gateway_ip) & cfg.subnet_mask) == 32'd0);

    assign waiting    = (state == ST_WAIT);
    assign timer_done = (timer == '0);

    assign lookup_ready = (state == ST_IDLE);
    assign query_valid  = (state == ST_QUERY) || waiting;
    assign query_ip     = target_ip;
    assign request_ip   = target_ip;

    // a hit always wins over an expiring timer
    assign send_request = waiting && !query_hit && timer_done && (retry_left != '0);
    assign give_up      = waiting && !query_hit && timer_done && (retry_left == '0);

    assign response_valid = bcast_resp | (waiting & query_hit) | give_up;
    assign response_error = give_up;
    assign response_mac   = bcast_resp ? 48'hffff_ffff_ffff : query_mac;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            bcast_resp <= 1'b0;
            retry_left <= '0;
            timer      <= '0;
        end else begin
            bcast_resp <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (lookup_valid) begin
                        if (is_bcast) begin
                            bcast_resp <= 1'b1;
                        end else begin
                            state <= ST_QUERY;
                        end
                    end
                end
                ST_QUERY: begin
                    // timer starts expired so a first miss sends at once
                    state      <= ST_WAIT;
                    retry_left <= RETRY_W'(`ARP_RETRY_COUNT);
                    timer      <= '0;
                end
                ST_WAIT: begin
                    if (query_hit || give_up) begin
                        state <= ST_IDLE;
                    end else if (send_request) begin
                        retry_left <= retry_left - 1'b1;
                        // last frame gets the long timeout
                        timer <= (retry_left > 1) ? INTERVAL_LOAD : TIMEOUT_LOAD;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // off-subnet hosts resolve through the gateway
    always_ff @(posedge clk) begin
        if (lookup_ready && lookup_valid) begin
            target_ip <= in_subnet ? lookup_ip : cfg.gateway_ip;
        end
    end

endmodule

// ==== arp_offload.f ====
+incdir+common
common/arp_pkg.sv
arp/arp_frame_decode.sv
arp/arp_cache.sv
arp/arp_lookup_engine.sv
arp/arp_frame_tx.sv
rtl/arp_top.sv
testbench/arp_tb.sv

// ==== common/arp_params.svh ====
// ARP operation codes and fixed header field values
// cache geometry and request retry timing
`ifndef ARP_PARAMS_SVH
`define ARP_PARAMS_SVH

// operation codes
`define ARP_OPER_REQUEST        16'h0001
`define ARP_OPER_REPLY          16'h0002
`define ARP_OPER_INARP_REQUEST  16'h0008
`define ARP_OPER_INARP_REPLY    16'h0009

// constant type fields of an ARP over Ethernet frame
`define ARP_ETH_TYPE            16'h0806
`define ARP_HTYPE_ETH           16'h0001
`define ARP_PTYPE_IPV4          16'h0800

// cache index width, four entries
`define ARP_CACHE_ADDR_WIDTH    2

// request frames sent before giving up
`define ARP_RETRY_COUNT         4

// cycles between request frames
`define ARP_RETRY_INTERVAL      64

// cycles after the last request frame until the error
`define ARP_REQUEST_TIMEOUT     256

`define ARP_TIMER_WIDTH         16

`endif

// ==== common/arp_pkg.sv ====
// address, frame, configuration and cache types
// shared by all blocks of the ARP offload
package arp_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;

    // whole decoded ARP frame, Ethernet header included
    typedef struct packed {
        mac_t        eth_dest_mac;
        mac_t        eth_src_mac;
        logic [15:0] eth_type;
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [15:0] oper;
        mac_t        sha;
        ip_t         spa;
        mac_t        tha;
        ip_t         tpa;
    } arp_frame_t;

    // local station configuration
    typedef struct packed {
        mac_t local_mac;
        ip_t  local_ip;
        ip_t  gateway_ip;
        ip_t  subnet_mask;
    } arp_cfg_t;

    // operations the decoder cares about
    typedef enum logic [1:0] {
        kind_request,
        kind_inarp_request,
        kind_other
    } arp_kind_e;

    // address pair, for cache writes and reply targets
    typedef struct packed {
        ip_t  ip;
        mac_t mac;
    } cache_entry_t;

endpackage

// ==== rtl/arp_top.sv ====
// ARP offload top level
// decoder, lookup engine, cache and frame transmitter
`timescale 1ns/100ps

module arp_top (
    input  logic                clk,
    input  logic                rst,
    input  arp_pkg::arp_frame_t in_frame,
    input  logic                in_frame_valid,
    output logic                in_frame_ready,
    output arp_pkg::arp_frame_t out_frame,
    output logic                out_frame_valid,
    input  logic                out_frame_ready,
    input  logic                lookup_valid,
    input  arp_pkg::ip_t        lookup_ip,
    output logic                lookup_ready,
    output logic                response_valid,
    output logic                response_error,
    output arp_pkg::mac_t       response_mac,
    input  arp_pkg::arp_cfg_t   cfg,
    input  logic                clear_cache
);

    logic                  rx_ready;
    logic                  reply_valid;
    logic [15:0]           reply_oper;
    arp_pkg::mac_t         reply_dest_mac;
    arp_pkg::cache_entry_t reply_target;
    logic                  learn_valid;
    arp_pkg::cache_entry_t learn_entry;
    logic                  query_valid;
    arp_pkg::ip_t          query_ip;
    logic                  query_hit;
    arp_pkg::mac_t         query_mac;
    logic                  send_request;
    arp_pkg::ip_t          request_ip;

    assign in_frame_ready = rx_ready;

    arp_frame_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .in_frame       (in_frame),
        .in_frame_valid (in_frame_valid),
        .rx_ready       (rx_ready),
        .cfg            (cfg),
        .reply_valid    (reply_valid),
        .reply_oper     (reply_oper),
        .reply_dest_mac (reply_dest_mac),
        .reply_target   (reply_target),
        .learn_valid    (learn_valid),
        .learn_entry    (learn_entry)
    );

    arp_cache u_cache (
        .clk         (clk),
        .rst         (rst),
        .clear_cache (clear_cache),
        .learn_valid (learn_valid),
        .learn_entry (learn_entry),
        .query_valid (query_valid),
        .query_ip    (query_ip),
        .query_hit   (query_hit),
        .query_mac   (query_mac)
    );

    arp_lookup_engine u_engine (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg),
        .lookup_valid   (lookup_valid),
        .lookup_ip      (lookup_ip),
        .lookup_ready   (lookup_ready),
        .query_valid    (query_valid),
        .query_ip       (query_ip),
        .query_hit      (query_hit),
        .query_mac      (query_mac),
        .send_request   (send_request),
        .request_ip     (request_ip),
        .response_valid (response_valid),
        .response_error (response_error),
        .response_mac   (response_mac)
    );

    arp_frame_tx u_tx (
        .clk             (clk),
        .rst             (rst),
        .cfg             (cfg),
        .reply_valid     (reply_valid),
        .reply_oper      (reply_oper),
        .reply_dest_mac  (reply_dest_mac),
        .reply_target    (reply_target),
        .send_request    (send_request),
        .request_ip      (request_ip),
        .rx_ready        (rx_ready),
        .out_frame       (out_frame),
        .out_frame_valid (out_frame_valid),
        .out_frame_ready (out_frame_ready)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ARP offload testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module arp_tb -f arp_offload.f -o arp_sim > build.log 2>&1 ||
    { cat build.log; echo "build failed"; exit 1; }
./obj_dir/arp_sim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "PASS" && exit 0

// ==== testbench/arp_tb.sv ====
// ARP offload testbench
// random ARP frames and host lookups, a peer station answering requests,
// a reference model of the cache contents and the closing error counts
`timescale 1ns/100ps
`include "arp_params.svh"

module arp_tb;

    localparam int ENTRIES     = 2 ** `ARP_CACHE_ADDR_WIDTH;
    localparam int NUM_FRAMES  = 40;
    localparam int NUM_LOOKUPS = ENTRIES + 4;
    localparam int MAX_WAIT    = `ARP_RETRY_COUNT * `ARP_RETRY_INTERVAL + `ARP_REQUEST_TIMEOUT;
    localparam int CYCLE_LIMIT = 16 + NUM_FRAMES * 32 + NUM_LOOKUPS * (MAX_WAIT + 64);

    logic                clk;
    logic                rst;
    arp_pkg::arp_frame_t in_frame;
    logic                in_frame_valid;
    logic                in_frame_ready;
    arp_pkg::arp_frame_t out_frame;
    logic                out_frame_valid;
    logic                out_frame_ready;
    logic                lookup_valid;
    arp_pkg::ip_t        lookup_ip;
    logic                lookup_ready;
    logic                response_valid;
    logic                response_error;
    arp_pkg::mac_t       response_mac;
    arp_pkg::arp_cfg_t   cfg;
    logic                clear_cache;

    integer              seed;
    int                  cycle = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  fails = 0;
    int                  req_count;
    arp_pkg::ip_t        exp_req_ip;
    arp_pkg::mac_t       gw_mac;
    arp_pkg::arp_frame_t tx_q [$];
    int                  tx_due [$];
    arp_pkg::arp_frame_t exp_q [$];
    arp_pkg::mac_t       peer_table [arp_pkg::ip_t];

    // cache reference model with the same index rule as the DUT
    logic                model_valid [ENTRIES];
    arp_pkg::ip_t        model_ip [ENTRIES];
    arp_pkg::mac_t       model_mac [ENTRIES];

    arp_top UUT (
        .clk             (clk),
        .rst             (rst),
        .in_frame        (in_frame),
        .in_frame_valid  (in_frame_valid),
        .in_frame_ready  (in_frame_ready),
        .out_frame       (out_frame),
        .out_frame_valid (out_frame_valid),
        .out_frame_ready (out_frame_ready),
        .lookup_valid    (lookup_valid),
        .lookup_ip       (lookup_ip),
        .lookup_ready    (lookup_ready),
        .response_valid  (response_valid),
        .response_error  (response_error),
        .response_mac    (response_mac),
        .cfg             (cfg),
        .clear_cache     (clear_cache)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input logic [319:0] got, input logic [319:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        fails++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    function automatic logic type_ok(input arp_pkg::arp_frame_t f);
        return f.eth_type == `ARP_ETH_TYPE && f.htype == `ARP_HTYPE_ETH &&
               f.ptype == `ARP_PTYPE_IPV4;
    endfunction

    function automatic arp_pkg::mac_t random_mac();
        return {16'($random(seed)), 32'($random(seed))};
    endfunction

    // hosts 2 to 253 stay clear of local, gateway and broadcast
    function automatic arp_pkg::ip_t random_host_ip();
        return {cfg.local_ip[31:8], 8'(2 + ($unsigned($random(seed)) % 252))};
    endfunction

    function automatic arp_pkg::arp_frame_t make_frame(input int kind);
        arp_pkg::arp_frame_t f;
        f.eth_dest_mac = 48'hffff_ffff_ffff;
        f.eth_src_mac  = random_mac();
        f.eth_type     = `ARP_ETH_TYPE;
        f.htype        = `ARP_HTYPE_ETH;
        f.ptype        = `ARP_PTYPE_IPV4;
        f.oper         = `ARP_OPER_REQUEST;
        f.sha          = random_mac();
        f.spa          = random_host_ip();
        f.tha          = '0;
        f.tpa          = cfg.local_ip;
        case (kind)
            1: begin
                f.oper = `ARP_OPER_INARP_REQUEST;
                f.tha  = cfg.local_mac;
                f.tpa  = '0;
            end
            // request for another host
            2: f.tpa = random_host_ip();
            3: f.eth_type = 16'h0800;
            4: f.oper = `ARP_OPER_REPLY;
            5: begin
                f.oper = `ARP_OPER_INARP_REQUEST;
                f.tha  = random_mac();
            end
            default: f.tpa = cfg.local_ip;
        endcase
        return f;
    endfunction

    function automatic logic wants_reply(input arp_pkg::arp_frame_t f);
        return type_ok(f) &&
               ((f.oper == `ARP_OPER_REQUEST && f.tpa == cfg.local_ip) ||
                (f.oper == `ARP_OPER_INARP_REQUEST && f.tha == cfg.local_mac));
    endfunction

    // reply goes back to the sender with our addresses as source
    function automatic arp_pkg::arp_frame_t expected_reply(input arp_pkg::arp_frame_t f);
        arp_pkg::arp_frame_t r;
        r.eth_dest_mac = f.eth_src_mac;
        r.eth_src_mac  = cfg.local_mac;
        r.eth_type     = `ARP_ETH_TYPE;
        r.htype        = `ARP_HTYPE_ETH;
        r.ptype        = `ARP_PTYPE_IPV4;
        r.oper         = (f.oper == `ARP_OPER_REQUEST) ? `ARP_OPER_REPLY : `ARP_OPER_INARP_REPLY;
        r.sha          = cfg.local_mac;
        r.spa          = cfg.local_ip;
        r.tha          = f.sha;
        r.tpa          = f.spa;
        return r;
    endfunction

    task automatic queue_frame(input arp_pkg::arp_frame_t f, input int delay);
        tx_q.push_back(f);
        tx_due.push_back(cycle + delay);
    endtask

    task automatic take_out_frame(input arp_pkg::arp_frame_t f);
        arp_pkg::arp_frame_t r;
        if (f.oper == `ARP_OPER_REQUEST) begin
            req_count++;
            check("request eth_dest_mac", 320'(f.eth_dest_mac), 320'(48'hffff_ffff_ffff));
            check("request tha", 320'(f.tha), '0);
            check("request tpa", 320'(f.tpa), 320'(exp_req_ip));
            check("request sha", 320'(f.sha), 320'(cfg.local_mac));
            check("request spa", 320'(f.spa), 320'(cfg.local_ip));
            // peer station answers a few cycles later
            if (peer_table.exists(f.tpa)) begin
                r.eth_dest_mac = f.sha;
                r.eth_src_mac  = peer_table[f.tpa];
                r.eth_type     = `ARP_ETH_TYPE;
                r.htype        = `ARP_HTYPE_ETH;
                r.ptype        = `ARP_PTYPE_IPV4;
                r.oper         = `ARP_OPER_REPLY;
                r.sha          = peer_table[f.tpa];
                r.spa          = f.tpa;
                r.tha          = f.sha;
                r.tpa          = f.spa;
                queue_frame(r, 3);
            end
        end else if (exp_q.size() == 0) begin
            report_failure("an output frame appeared while no reply was due");
        end else begin
            r = exp_q.pop_front();
            check("out_frame.oper", 320'(f.oper), 320'(r.oper));
            check("out_frame.eth_dest_mac", 320'(f.eth_dest_mac), 320'(r.eth_dest_mac));
            check("out_frame.tha", 320'(f.tha), 320'(r.tha));
            check("out_frame.tpa", 320'(f.tpa), 320'(r.tpa));
            check("out_frame", f, r);
        end
    endtask

    // one clock cycle with all inputs changed on the falling edge
    task automatic tick();
        logic                take;
        arp_pkg::arp_frame_t f;
        @(negedge clk);
        lookup_valid = 1'b0;
        take = (($random(seed) & 3) != 0);
        if (out_frame_valid && take) begin
            take_out_frame(out_frame);
        end
        out_frame_ready = take;
        in_frame_valid = 1'b0;
        if (tx_q.size() > 0 && tx_due[0] <= cycle && in_frame_ready) begin
            f = tx_q.pop_front();
            void'(tx_due.pop_front());
            in_frame = f;
            in_frame_valid = 1'b1;
            if (wants_reply(f)) begin
                exp_q.push_back(expected_reply(f));
            end
        end
    endtask

    task automatic drain();
        while (tx_q.size() > 0 || exp_q.size() > 0 || out_frame_valid) begin
            tick();
        end
        repeat (4) tick();
    endtask

    task automatic lookup(input arp_pkg::ip_t ip, input arp_pkg::mac_t exp_mac,
                          input logic exp_err, input int exp_latency);
        int start;
        tick();
        while (!lookup_ready) begin
            tick();
        end
        lookup_valid = 1'b1;
        lookup_ip    = ip;
        start        = cycle;
        tick();
        while (!response_valid) begin
            tick();
        end
        check("response_error", 320'(response_error), 320'(exp_err));
        if (!exp_err) begin
            check("response_mac", 320'(response_mac), 320'(exp_mac));
        end
        if (exp_latency != 0) begin
            check("response latency", 320'(cycle - start), 320'(exp_latency));
        end
    endtask

    task automatic flush_cache();
        tick();
        clear_cache = 1'b1;
        tick();
        clear_cache = 1'b0;
        repeat (2) tick();
    endtask

    // cycle count, reference cache and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst || clear_cache) begin
            for (int i = 0; i < ENTRIES; i++) begin
                model_valid[i] <= 1'b0;
            end
        end else if (in_frame_valid && type_ok(in_frame)) begin
            model_valid[in_frame.spa[`ARP_CACHE_ADDR_WIDTH-1:0]] <= 1'b1;
            model_ip[in_frame.spa[`ARP_CACHE_ADDR_WIDTH-1:0]]    <= in_frame.spa;
            model_mac[in_frame.spa[`ARP_CACHE_ADDR_WIDTH-1:0]]   <= in_frame.sha;
        end
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("checks %0d, value errors %0d, other failures %0d",
                     checks, errors, fails + 1);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        seed            = 32'hd2c6_2e1f;
        rst             = 1'b1;
        in_frame        = '0;
        in_frame_valid  = 1'b0;
        out_frame_ready = 1'b0;
        lookup_valid    = 1'b0;
        lookup_ip       = '0;
        clear_cache     = 1'b0;
        req_count       = 0;
        exp_req_ip      = '0;
        cfg.local_mac   = 48'h02_00_5e_10_00_01;
        cfg.local_ip    = 32'h0a00_0001;
        cfg.gateway_ip  = 32'h0a00_00fe;
        cfg.subnet_mask = 32'hffff_ff00;
        gw_mac          = random_mac();
        peer_table[cfg.gateway_ip] = gw_mac;
        repeat (16) @(negedge clk);

        // idle state out of reset
        check("in_frame_ready", 320'(in_frame_ready), 320'(1));
        check("lookup_ready", 320'(lookup_ready), 320'(1));
        check("out_frame_valid", 320'(out_frame_valid), 320'(0));
        check("response_valid", 320'(response_valid), 320'(0));
        rst = 1'b0;

        // replies, drops and learning
        for (int n = 0; n < NUM_FRAMES; n++) begin
            queue_frame(make_frame($unsigned($random(seed)) % 6), 1);
        end
        drain();

        // learned in-subnet addresses hit two cycles after acceptance
        for (int i = 0; i < ENTRIES; i++) begin
            if (model_valid[i]) begin
                lookup(model_ip[i], model_mac[i], 1'b0, 2);
            end
        end

        // broadcast addresses answer at once
        lookup(cfg.local_ip | ~cfg.subnet_mask, 48'hffff_ffff_ffff, 1'b0, 1);
        lookup(32'hffff_ffff, 48'hffff_ffff_ffff, 1'b0, 1);

        // unknown host that nobody answers
        flush_cache();
        exp_req_ip = 32'h0a00_0077;
        req_count  = 0;
        lookup(exp_req_ip, '0, 1'b1, 0);
        check("request frame count", 320'(req_count), 320'(`ARP_RETRY_COUNT));

        // off-subnet host resolves through the gateway
        exp_req_ip = cfg.gateway_ip;
        req_count  = 0;
        lookup(32'hc0a8_0105, gw_mac, 1'b0, 0);
        check("request frame count", 320'(req_count), 320'(1));
        drain();

        $display("checks %0d, value errors %0d, other failures %0d", checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
